// ==== common/axi_chan_pkg.sv ====
/*
 * AXI4 bus widths for the isolator
 * Channel payload structs for AW, W, B, AR and R
 * Request and response bundles for one AXI port
 */

package axi_chan_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ID_W   = 4;
  localparam int unsigned STRB_W = DATA_W / 8;
  localparam int unsigned LEN_W  = 8;
  localparam int unsigned RESP_W = 2;

  ////////////////////////////////////////
  // Channel payloads
  ////////////////////////////////////////

  // Write address
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } aw_chan_t;

  // Write data beat
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_chan_t;

  // Write response
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [RESP_W-1:0] resp;
  } b_chan_t;

  // Read address, same layout as AW
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } ar_chan_t;

  // Read data beat
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [RESP_W-1:0] resp;
    logic              last;
  } r_chan_t;

  ////////////////////////////////////////
  // Port bundles
  ////////////////////////////////////////

  // Everything the manager drives
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Everything the subordinate drives
  typedef struct packed {
    logic     aw_ready;
    logic     ar_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    r_chan_t  r;
    logic     r_valid;
  } axi_resp_t;

endpackage

// ==== common/isolate_pkg.sv ====
/*
 * Isolation gate state encoding
 * AXI response code used by the isolator environment
 */

package isolate_pkg;

  // Per address channel gate states
  // ISOLATE is the reset state, so the bus starts cut off
  typedef enum logic [1:0] {
    NORMAL  = 2'b00,
    HOLD    = 2'b01,
    DRAIN   = 2'b10,
    ISOLATE = 2'b11
  } gate_state_e;

  // Successful completion of a transfer
  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

// ==== txn_gate/txn_gate.sv ====
/*
 * Address channel isolation gate
 * NORMAL / HOLD / DRAIN / ISOLATE state machine
 * Outstanding transaction counter with full back-pressure
 */

`timescale 1ns/1ps

module txn_gate #(
  parameter int unsigned NUM_PENDING = 16,
  parameter type         chan_t      = logic
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     isolate_i,
  input  logic                     slv_valid_i,
  input  logic                     mst_ready_i,
  input  logic                     done_i,
  input  logic                     stall_i,
  input  chan_t                    slv_chan_i,
  output logic                     mst_valid_o,
  output logic                     slv_ready_o,
  output logic                     accept_o,
  output chan_t                    mst_chan_o,
  output isolate_pkg::gate_state_e state_o
);
  import isolate_pkg::*;

  // Room for zero up to NUM_PENDING open transactions
  localparam int unsigned CNT_W = $clog2(NUM_PENDING + 1);

  typedef logic [CNT_W-1:0] cnt_t;

  gate_state_e state_q;
  gate_state_e state_d;
  cnt_t        cnt_q;
  cnt_t        cnt_d;
  logic        full;
  logic        block;
  logic        active;

  // Counter at its limit or an outside stall blocks new addresses
  assign full  = (cnt_q >= cnt_t'(NUM_PENDING));
  assign block = full | stall_i;

  // Handshakes count only while the channel is connected
  assign active   = (state_q == NORMAL) | (state_q == HOLD);
  assign accept_o = active & mst_valid_o & mst_ready_i;

  assign state_o = state_q;

  ////////////////////////////////////////
  // Gate state machine
  ////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    // Cut by default
    mst_valid_o = 1'b0;
    slv_ready_o = 1'b0;
    mst_chan_o  = '0;

    case (state_q)
      NORMAL: begin
        mst_chan_o = slv_chan_i;
        if (block) begin
          // Handshake held off until the count falls
          if (isolate_i) begin
            state_d = DRAIN;
          end
        end else begin
          // Straight pass-through
          mst_valid_o = slv_valid_i;
          slv_ready_o = mst_ready_i;
          if (slv_valid_i && !mst_ready_i) begin
            // Valid is out, must stay up until taken
            state_d = HOLD;
          end else if (isolate_i) begin
            state_d = DRAIN;
          end
        end
      end

      HOLD: begin
        // Keep the pending address on the bus, even under isolation
        mst_chan_o  = slv_chan_i;
        mst_valid_o = 1'b1;
        slv_ready_o = mst_ready_i;
        if (mst_ready_i) begin
          state_d = isolate_i ? DRAIN : NORMAL;
        end
      end

      DRAIN: begin
        // No new addresses, wait for open ones to finish
        if (cnt_q == '0) begin
          state_d = ISOLATE;
        end
      end

      ISOLATE: begin
        if (!isolate_i) begin
          state_d = NORMAL;
        end
      end

      default: begin
        state_d = ISOLATE;
      end
    endcase
  end

  ////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////

  always_comb begin
    case ({accept_o, done_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      // Start and finish in one cycle cancel out
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ISOLATE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

endmodule

// ==== rtl/w_tracker.sv ====
/*
 * Pending W burst tracker
 * Opens the W channel only for bursts whose AW went out
 */

`timescale 1ns/1ps

module w_tracker #(
  parameter int unsigned NUM_PENDING = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  aw_accept_i,
  input  axi_chan_pkg::w_chan_t slv_w_i,
  input  logic                  slv_w_valid_i,
  input  logic                  mst_w_ready_i,
  output axi_chan_pkg::w_chan_t mst_w_o,
  output logic                  mst_w_valid_o,
  output logic                  slv_w_ready_o,
  output logic                  w_full_o
);

  // Zero through NUM_PENDING open bursts
  localparam int unsigned CNT_W = $clog2(NUM_PENDING + 1);

  typedef logic [CNT_W-1:0] cnt_t;

  cnt_t cnt_q;
  cnt_t cnt_d;
  logic w_last_hs;
  logic w_open;

  // Final beat of a burst leaves on the master side
  assign w_last_hs = mst_w_valid_o & mst_w_ready_i & mst_w_o.last;

  // An AW in this same cycle already unlocks its data
  assign w_open = (cnt_q != '0) | aw_accept_i;

  // W pass-through, zeroed while no burst is open
  assign mst_w_o       = w_open ? slv_w_i : '0;
  assign mst_w_valid_o = w_open & slv_w_valid_i;
  assign slv_w_ready_o = w_open & mst_w_ready_i;

  // Stalls the AW gate at the limit
  assign w_full_o = (cnt_q >= cnt_t'(NUM_PENDING));

  always_comb begin
    case ({aw_accept_i, w_last_hs})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule

// ==== rtl/axi_isolate.sv ====
/*
 * AXI4 bus isolator top level
 * Write address gate, read address gate and W burst tracker
 * Cuts B and R while isolated and reports isolated_o
 */

`timescale 1ns/1ps

module axi_isolate #(
  parameter int unsigned NUM_PENDING = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  isolate_i,
  input  axi_chan_pkg::axi_req_t  slv_req_i,
  output axi_chan_pkg::axi_resp_t slv_resp_o,
  output axi_chan_pkg::axi_req_t  mst_req_o,
  input  axi_chan_pkg::axi_resp_t mst_resp_i,
  output logic                  isolated_o
);
  import axi_chan_pkg::*;
  import isolate_pkg::*;

  // Gate states
  gate_state_e aw_state;
  gate_state_e ar_state;

  // Master side address channels from the gates
  aw_chan_t mst_aw;
  ar_chan_t mst_ar;
  logic     mst_aw_valid;
  logic     mst_ar_valid;
  logic     slv_aw_ready;
  logic     slv_ar_ready;

  // Transaction bookkeeping
  logic aw_accept;
  logic aw_done;
  logic ar_done;
  logic w_full;

  // Master side W from the tracker
  w_chan_t mst_w;
  logic    mst_w_valid;
  logic    slv_w_ready;

  // Response channels are cut only once fully isolated
  logic b_cut;
  logic r_cut;

  assign b_cut = (aw_state == ISOLATE);
  assign r_cut = (ar_state == ISOLATE);

  // A write ends with its B handshake, a read with its last R beat
  assign aw_done = mst_req_o.b_ready & mst_resp_i.b_valid;
  assign ar_done = mst_req_o.r_ready & mst_resp_i.r_valid & mst_resp_i.r.last;

  ////////////////////////////////////////
  // Write side
  ////////////////////////////////////////

  txn_gate #(
    .NUM_PENDING (NUM_PENDING),
    .chan_t      (aw_chan_t)
  ) u_aw_gate (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .isolate_i   (isolate_i),
    .slv_valid_i (slv_req_i.aw_valid),
    .mst_ready_i (mst_resp_i.aw_ready),
    .done_i      (aw_done),
    .stall_i     (w_full),
    .slv_chan_i  (slv_req_i.aw),
    .mst_valid_o (mst_aw_valid),
    .slv_ready_o (slv_aw_ready),
    .accept_o    (aw_accept),
    .mst_chan_o  (mst_aw),
    .state_o     (aw_state)
  );

  w_tracker #(
    .NUM_PENDING (NUM_PENDING)
  ) u_w_tracker (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .aw_accept_i   (aw_accept),
    .slv_w_i       (slv_req_i.w),
    .slv_w_valid_i (slv_req_i.w_valid),
    .mst_w_ready_i (mst_resp_i.w_ready),
    .mst_w_o       (mst_w),
    .mst_w_valid_o (mst_w_valid),
    .slv_w_ready_o (slv_w_ready),
    .w_full_o      (w_full)
  );

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  // Reads have no data side counter, so nothing stalls AR from outside
  txn_gate #(
    .NUM_PENDING (NUM_PENDING),
    .chan_t      (ar_chan_t)
  ) u_ar_gate (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .isolate_i   (isolate_i),
    .slv_valid_i (slv_req_i.ar_valid),
    .mst_ready_i (mst_resp_i.ar_ready),
    .done_i      (ar_done),
    .stall_i     (1'b0),
    .slv_chan_i  (slv_req_i.ar),
    .mst_valid_o (mst_ar_valid),
    .slv_ready_o (slv_ar_ready),
    .accept_o    (),
    .mst_chan_o  (mst_ar),
    .state_o     (ar_state)
  );

  ////////////////////////////////////////
  // Port assembly
  ////////////////////////////////////////

  always_comb begin
    // Request towards the master port
    mst_req_o.aw       = mst_aw;
    mst_req_o.aw_valid = mst_aw_valid;
    mst_req_o.w        = mst_w;
    mst_req_o.w_valid  = mst_w_valid;
    mst_req_o.b_ready  = b_cut ? 1'b0 : slv_req_i.b_ready;
    mst_req_o.ar       = mst_ar;
    mst_req_o.ar_valid = mst_ar_valid;
    mst_req_o.r_ready  = r_cut ? 1'b0 : slv_req_i.r_ready;

    // Response back to the slave port
    slv_resp_o.aw_ready = slv_aw_ready;
    slv_resp_o.ar_ready = slv_ar_ready;
    slv_resp_o.w_ready  = slv_w_ready;
    slv_resp_o.b        = b_cut ? '0 : mst_resp_i.b;
    slv_resp_o.b_valid  = b_cut ? 1'b0 : mst_resp_i.b_valid;
    slv_resp_o.r        = r_cut ? '0 : mst_resp_i.r;
    slv_resp_o.r_valid  = r_cut ? 1'b0 : mst_resp_i.r_valid;
  end

  // Isolated only when both directions are cut
  assign isolated_o = b_cut & r_cut;

endmodule

// ==== sim/axi_resp_model.sv ====
/*
 * Behavioral AXI slave for the isolator testbench
 * One B per write after a set delay, len+1 R beats per read
 * Hold input freezes all responses
 */

`timescale 1ns/1ps

module axi_resp_model (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    hold_i,
  input  logic [3:0]              delay_i,
  input  axi_chan_pkg::axi_req_t  req_i,
  output axi_chan_pkg::axi_resp_t resp_o
);
  import axi_chan_pkg::*;
  import isolate_pkg::*;

  // Writes waiting for their last W beat, then for B
  logic [ID_W-1:0] aw_ids[$];
  b_chan_t         b_q[$];
  int unsigned     b_due[$];
  // Reads waiting for R, beat index of the head burst
  ar_chan_t        ar_q[$];
  int unsigned     beat;
  int unsigned     cycle;

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      aw_ids.delete();
      b_q.delete();
      b_due.delete();
      ar_q.delete();
      beat   = 0;
      cycle  = 0;
      resp_o <= '0;
    end else begin
      cycle = cycle + 1;
      // Retire responses taken in this cycle
      if (resp_o.b_valid && req_i.b_ready) begin
        void'(b_q.pop_front());
        void'(b_due.pop_front());
      end
      if (resp_o.r_valid && req_i.r_ready) begin
        if (resp_o.r.last) begin
          void'(ar_q.pop_front());
          beat = 0;
        end else begin
          beat = beat + 1;
        end
      end
      // AW first, its W may end in the same cycle
      if (req_i.aw_valid && resp_o.aw_ready) begin
        aw_ids.push_back(req_i.aw.id);
      end
      if (req_i.w_valid && resp_o.w_ready && req_i.w.last && aw_ids.size() > 0) begin
        b_q.push_back('{id: aw_ids.pop_front(), resp: RESP_OKAY});
        b_due.push_back(cycle + delay_i);
      end
      if (req_i.ar_valid && resp_o.ar_ready) begin
        ar_q.push_back(req_i.ar);
      end
      // Address and data always taken
      resp_o.aw_ready <= 1'b1;
      resp_o.w_ready  <= 1'b1;
      resp_o.ar_ready <= 1'b1;
      // A raised valid stays up until taken
      if (!resp_o.b_valid || req_i.b_ready) begin
        resp_o.b_valid <= 1'b0;
        if (b_q.size() > 0 && !hold_i && cycle >= b_due[0]) begin
          resp_o.b_valid <= 1'b1;
          resp_o.b       <= b_q[0];
        end
      end
      if (!resp_o.r_valid || req_i.r_ready) begin
        resp_o.r_valid <= 1'b0;
        if (ar_q.size() > 0 && !hold_i) begin
          resp_o.r_valid <= 1'b1;
          resp_o.r.id    <= ar_q[0].id;
          resp_o.r.data  <= DATA_W'(ar_q[0].addr + beat);
          resp_o.r.resp  <= RESP_OKAY;
          resp_o.r.last  <= (beat == ar_q[0].len);
        end
      end
    end
  end

endmodule

// ==== sim/tb_axi_isolate.sv ====
/*
 * Testbench for the AXI4 bus isolator
 * Table of writes, reads and isolation steps applied in a loop
 * Response monitor, typed compare tasks and the final report
 */

`timescale 1ns/1ps

module tb_axi_isolate;
  import axi_chan_pkg::*;
  import isolate_pkg::*;

  localparam int unsigned NUM_PENDING = 4;
  localparam int unsigned TIMEOUT     = 200;
  localparam int unsigned NUM_ROWS    = 18;
  // Channel selectors for the ready wait
  localparam int CH_AW = 0;
  localparam int CH_W  = 1;
  localparam int CH_AR = 2;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_WATCH, OP_DRAIN} op_e;

  // One step: exp is the expected ready for requests, else isolated_o
  typedef struct packed {
    logic [2:0]        test;
    op_e               op;
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic              iso;
    logic              hold;
    logic              exp;
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        isolate;
  logic        isolated;
  logic        model_hold;
  logic [3:0]  model_delay;
  axi_req_t    slv_req;
  axi_resp_t   slv_resp;
  axi_req_t    mst_req;
  axi_resp_t   mst_resp;
  row_t        rows[NUM_ROWS];
  b_chan_t     exp_b[$];
  b_chan_t     got_b[$];
  r_chan_t     exp_r[$];
  r_chan_t     got_r[$];
  int unsigned errors;
  int unsigned checks;
  int unsigned tests;
  int unsigned test_err_start;
  logic        timed_out;

  axi_isolate #(
    .NUM_PENDING (NUM_PENDING)
  ) u_dut (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .isolate_i  (isolate),
    .slv_req_i  (slv_req),
    .slv_resp_o (slv_resp),
    .mst_req_o  (mst_req),
    .mst_resp_i (mst_resp),
    .isolated_o (isolated)
  );

  axi_resp_model u_model (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .hold_i  (model_hold),
    .delay_i (model_delay),
    .req_i   (mst_req),
    .resp_o  (mst_resp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Collect slave side responses on each handshake
  always @(posedge clk) begin
    if (rst_n && slv_resp.b_valid && slv_req.b_ready) begin
      got_b.push_back(slv_resp.b);
    end
    if (rst_n && slv_resp.r_valid && slv_req.r_ready) begin
      got_r.push_back(slv_resp.r);
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_b(input b_chan_t got, input b_chan_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: B id %0h resp %0h, expected id %0h resp %0h",
               $time, got.id, got.resp, exp.id, exp.resp);
    end
  endtask

  task automatic check_r(input r_chan_t got, input r_chan_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: R id %0h data %h last %b, expected id %0h data %h last %b",
               $time, got.id, got.data, got.last, exp.id, exp.data, exp.last);
    end
  endtask

  ////////////////////////////////////////
  // Bounded waits
  ////////////////////////////////////////

  task automatic wait_ready(input int chan, input string what);
    int unsigned n;
    logic        rdy;
    n   = 0;
    rdy = 1'b0;
    while (!rdy && !timed_out) begin
      @(posedge clk);
      case (chan)
        CH_AW:   rdy = slv_resp.aw_ready;
        CH_W:    rdy = slv_resp.w_ready;
        default: rdy = slv_resp.ar_ready;
      endcase
      n++;
      if (!rdy && n >= TIMEOUT) begin
        $display("Timeout: no handshake on %s at %0t", what, $time);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic wait_responses();
    int unsigned n;
    n = 0;
    while ((got_b.size() < exp_b.size() || got_r.size() < exp_r.size()) && !timed_out) begin
      @(posedge clk);
      n++;
      if (n >= TIMEOUT) begin
        $display("Timeout: responses missing, %0d of %0d B and %0d of %0d R arrived",
                 got_b.size(), exp_b.size(), got_r.size(), exp_r.size());
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic wait_isolated(input logic exp);
    int unsigned n;
    n = 0;
    while (isolated !== exp && !timed_out) begin
      @(posedge clk);
      n++;
      if (isolated !== exp && n >= TIMEOUT) begin
        $display("Timeout: isolated_o never reached %b", exp);
        timed_out = 1'b1;
      end
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Starts at a falling edge, issues the address and any W beats
  task automatic send_request(input row_t r);
    int unsigned k;
    model_delay = 4'($urandom % 4);
    if (r.op == OP_WR) begin
      slv_req.aw       = '{id: r.id, addr: r.addr, len: r.len, size: 3'd2, burst: 2'b01};
      slv_req.aw_valid = 1'b1;
    end else begin
      slv_req.ar       = '{id: r.id, addr: r.addr, len: r.len, size: 3'd2, burst: 2'b01};
      slv_req.ar_valid = 1'b1;
    end
    if (!r.exp) begin
      // Blocked request must neither be taken nor reach the master port
      repeat (4) begin
        @(posedge clk);
        check_bit(r.op == OP_WR ? slv_resp.aw_ready : slv_resp.ar_ready, 1'b0,
                  "slave address ready");
        check_bit(mst_req.aw_valid | mst_req.ar_valid, 1'b0, "master address valid");
      end
      // Release clears both isolation and the model hold
      @(negedge clk);
      isolate    = 1'b0;
      model_hold = 1'b0;
    end
    wait_ready(r.op == OP_WR ? CH_AW : CH_AR, "address channel");
    @(negedge clk);
    slv_req.aw_valid = 1'b0;
    slv_req.ar_valid = 1'b0;
    if (r.op == OP_WR) begin
      exp_b.push_back('{id: r.id, resp: RESP_OKAY});
      for (k = 0; k <= r.len; k++) begin
        slv_req.w       = '{data: DATA_W'(r.addr + k), strb: '1, last: (k == r.len)};
        slv_req.w_valid = 1'b1;
        wait_ready(CH_W, "W channel");
        @(negedge clk);
      end
      slv_req.w_valid = 1'b0;
    end else begin
      // Beat k returns address plus k
      for (k = 0; k <= r.len; k++) begin
        exp_r.push_back('{id: r.id, data: DATA_W'(r.addr + k), resp: RESP_OKAY,
                          last: (k == r.len)});
      end
    end
  endtask

  // Ends a test once all responses and the isolation level are in
  task automatic finish_test(input row_t r);
    wait_responses();
    while (exp_b.size() > 0 && got_b.size() > 0) begin
      check_b(got_b.pop_front(), exp_b.pop_front());
    end
    while (exp_r.size() > 0 && got_r.size() > 0) begin
      check_r(got_r.pop_front(), exp_r.pop_front());
    end
    check_bit(got_b.size() + got_r.size() != 0, 1'b0, "extra responses");
    exp_b.delete();
    got_b.delete();
    exp_r.delete();
    got_r.delete();
    wait_isolated(r.exp);
    if (r.exp) begin
      check_bit(|mst_req, 1'b0, "master request while isolated");
    end
    tests++;
    $display("test %0d done, %0d errors", r.test, errors - test_err_start);
    test_err_start = errors;
  endtask

  initial begin
    int unsigned seed;
    int          i;
    row_t        cur;

    seed = $urandom(87);
    errors         = 0;
    checks         = 0;
    tests          = 0;
    test_err_start = 0;
    timed_out      = 1'b0;
    rst_n          = 1'b0;
    isolate        = 1'b0;
    model_hold     = 1'b0;
    model_delay    = 4'd0;
    slv_req         = '0;
    slv_req.b_ready = 1'b1;
    slv_req.r_ready = 1'b1;

    // test, op, id, addr, len, iso, hold, exp
    rows[0]  = '{3'd1, OP_WR,    4'd1,  32'h0000_1000, 8'd0, 1'b0, 1'b0, 1'b1};
    rows[1]  = '{3'd1, OP_DRAIN, 4'd0,  32'h0,         8'd0, 1'b0, 1'b0, 1'b0};
    rows[2]  = '{3'd2, OP_RD,    4'd2,  32'h0000_2000, 8'd3, 1'b0, 1'b0, 1'b1};
    rows[3]  = '{3'd2, OP_DRAIN, 4'd0,  32'h0,         8'd0, 1'b0, 1'b0, 1'b0};
    // Counter full after four held writes
    rows[4]  = '{3'd3, OP_WR,    4'd3,  32'h0000_3000, 8'd1, 1'b0, 1'b1, 1'b1};
    rows[5]  = '{3'd3, OP_WR,    4'd4,  32'h0000_3100, 8'd1, 1'b0, 1'b1, 1'b1};
    rows[6]  = '{3'd3, OP_WR,    4'd5,  32'h0000_3200, 8'd1, 1'b0, 1'b1, 1'b1};
    rows[7]  = '{3'd3, OP_WR,    4'd6,  32'h0000_3300, 8'd1, 1'b0, 1'b1, 1'b1};
    rows[8]  = '{3'd3, OP_WR,    4'd7,  32'h0000_3400, 8'd0, 1'b0, 1'b1, 1'b0};
    rows[9]  = '{3'd3, OP_DRAIN, 4'd0,  32'h0,         8'd0, 1'b0, 1'b0, 1'b0};
    // Isolation raised over open reads and writes
    rows[10] = '{3'd4, OP_WR,    4'd8,  32'h0000_4000, 8'd2, 1'b0, 1'b1, 1'b1};
    rows[11] = '{3'd4, OP_RD,    4'd9,  32'h0000_4100, 8'd1, 1'b0, 1'b1, 1'b1};
    rows[12] = '{3'd4, OP_WR,    4'd10, 32'h0000_4200, 8'd0, 1'b0, 1'b1, 1'b1};
    rows[13] = '{3'd4, OP_RD,    4'd11, 32'h0000_4300, 8'd2, 1'b0, 1'b1, 1'b1};
    rows[14] = '{3'd4, OP_WATCH, 4'd0,  32'h0,         8'd0, 1'b1, 1'b1, 1'b0};
    rows[15] = '{3'd4, OP_DRAIN, 4'd0,  32'h0,         8'd0, 1'b1, 1'b0, 1'b1};
    // Read while isolated, completes after release
    rows[16] = '{3'd5, OP_RD,    4'd12, 32'h0000_5000, 8'd1, 1'b1, 1'b0, 1'b0};
    rows[17] = '{3'd5, OP_DRAIN, 4'd0,  32'h0,         8'd0, 1'b0, 1'b0, 1'b0};

    repeat (8) @(posedge clk);
    check_bit(isolated, 1'b1, "isolated_o in reset");
    @(negedge clk);
    rst_n = 1'b1;

    for (i = 0; i < NUM_ROWS && !timed_out; i++) begin
      cur = rows[i];
      @(negedge clk);
      isolate    = cur.iso;
      model_hold = cur.hold;
      case (cur.op)
        OP_WR, OP_RD: send_request(cur);
        OP_WATCH: begin
          // Open transactions keep the isolator from closing
          repeat (6) begin
            @(posedge clk);
            check_bit(isolated, cur.exp, "isolated_o");
          end
        end
        default: finish_test(cur);
      endcase
    end

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
common/axi_chan_pkg.sv
common/isolate_pkg.sv
txn_gate/txn_gate.sv
rtl/w_tracker.sv
rtl/axi_isolate.sv
sim/axi_resp_model.sv
sim/tb_axi_isolate.sv
